// ==== source/icache_pkg.sv ====
package icache_pkg;

    // ------------------------------------------------------------
    // fetch and memory widths
    // ------------------------------------------------------------

    // byte address presented on the fetch port
    localparam int unsigned ADDR_WIDTH  = 32;
    // one instruction word
    localparam int unsigned FETCH_WIDTH = 32;
    // one read beat on the memory port
    localparam int unsigned BEAT_WIDTH  = 64;

    // ------------------------------------------------------------
    // line geometry
    // ------------------------------------------------------------

    // a line is filled by a two beat burst
    localparam int unsigned BEATS_PER_LINE    = 2;
    localparam int unsigned LINE_WIDTH        = BEATS_PER_LINE * BEAT_WIDTH;
    // byte offset bits inside a 16 byte line
    localparam int unsigned LINE_OFFSET_WIDTH = $clog2(LINE_WIDTH / 8);

    // ------------------------------------------------------------
    // shared types
    // ------------------------------------------------------------

    typedef logic [ADDR_WIDTH-1:0]  fetch_addr_t;
    typedef logic [FETCH_WIDTH-1:0] fetch_word_t;
    typedef logic [BEAT_WIDTH-1:0]  beat_t;

    // controller states
    // FLUSH is the reset state, it walks every set once
    typedef enum logic [2:0] {
        FLUSH,
        IDLE,
        TAG_CMP,
        REFILL,
        WAIT_R,
        REDO_REQ,
        TAG_CMP_SAVED
    } ctrl_state_e;

endpackage

// ==== source/icache_array_if.sv ====
interface icache_array_if #(
    parameter int unsigned NUM_WAYS = 4,
    parameter int unsigned NUM_SETS = 16
);
    import icache_pkg::*;

    localparam int unsigned INDEX_W    = $clog2(NUM_SETS);
    localparam int unsigned TAG_W      = ADDR_WIDTH - INDEX_W - LINE_OFFSET_WIDTH;
    localparam int unsigned WORD_SEL_W = LINE_OFFSET_WIDTH - $clog2(FETCH_WIDTH / 8);
    localparam int unsigned BEAT_SEL_W = $clog2(BEATS_PER_LINE);

    // read side, issued one cycle ahead of the compare
    logic                  rd_en;
    logic [INDEX_W-1:0]    index;
    // refill and invalidate writes
    logic                  we;
    logic [NUM_WAYS-1:0]   way_mask;
    logic [BEAT_SEL_W-1:0] beat_sel;
    beat_t                 wr_beat;
    logic [TAG_W-1:0]      wr_tag;
    logic                  wr_valid;
    // compare side, valid the cycle after rd_en
    logic [WORD_SEL_W-1:0] word_sel;
    logic [TAG_W-1:0]      cmp_tag;
    logic [NUM_WAYS-1:0]   hit;
    logic [NUM_WAYS-1:0]   way_valid;
    fetch_word_t           rd_word;

    modport ctrl (
        output rd_en, index, we, way_mask, beat_sel, wr_beat, wr_tag, wr_valid,
        output word_sel, cmp_tag,
        input  hit, way_valid, rd_word
    );

    modport arrays (
        input  rd_en, index, we, way_mask, beat_sel, wr_beat, wr_tag, wr_valid,
        input  word_sel, cmp_tag,
        output hit, way_valid, rd_word
    );

endinterface

// ==== source/icache_arrays.sv ====
module icache_arrays #(
    parameter int unsigned NUM_WAYS = 4,
    parameter int unsigned NUM_SETS = 16
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    icache_array_if.arrays arr
);
    import icache_pkg::*;

    localparam int unsigned INDEX_W        = $clog2(NUM_SETS);
    localparam int unsigned TAG_W          = ADDR_WIDTH - INDEX_W - LINE_OFFSET_WIDTH;
    localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / FETCH_WIDTH;

    // line storage, one beat per packed row
    typedef logic [BEATS_PER_LINE-1:0][BEAT_WIDTH-1:0] line_beats_t;
    // same line seen as instruction words for the select
    typedef logic [WORDS_PER_LINE-1:0][FETCH_WIDTH-1:0] line_words_t;

    // ------------------------------------------------------------
    // storage, one tag, valid and line memory per way
    // ------------------------------------------------------------

    logic [TAG_W-1:0] tag_mem  [NUM_WAYS][NUM_SETS];
    logic             vld_mem  [NUM_WAYS][NUM_SETS];
    line_beats_t      line_mem [NUM_WAYS][NUM_SETS];

    // registered read data, one entry per way
    logic [TAG_W-1:0] tag_rd  [NUM_WAYS];
    line_words_t      line_rd [NUM_WAYS];
    logic             vld_rd  [NUM_WAYS];

    // writes go to the masked ways only
    // a refill writes one beat of the line per cycle
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (arr.we && arr.way_mask[w]) begin
                tag_mem[w][arr.index] <= arr.wr_tag;
                vld_mem[w][arr.index] <= arr.wr_valid;
                // invalidate leaves the line data alone
                if (arr.wr_valid) begin
                    line_mem[w][arr.index][arr.beat_sel] <= arr.wr_beat;
                end
            end
            // all ways are read together at the same index
            if (arr.rd_en) begin
                tag_rd[w]  <= tag_mem[w][arr.index];
                line_rd[w] <= line_mem[w][arr.index];
            end
        end
    end

    // valid view starts cleared so nothing hits before the first read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                vld_rd[w] <= 1'b0;
            end
        end else if (arr.rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                vld_rd[w] <= vld_mem[w][arr.index];
            end
        end
    end

    // ------------------------------------------------------------
    // tag compare and word select
    // ------------------------------------------------------------

    always_comb begin
        arr.hit       = '0;
        arr.way_valid = '0;
        arr.rd_word   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            arr.way_valid[w] = vld_rd[w];
            // stale tags in invalid ways never hit
            arr.hit[w]       = vld_rd[w] && (tag_rd[w] == arr.cmp_tag);
            // at most one way hits, so an OR acts as the way mux
            if (arr.hit[w]) begin
                arr.rd_word = arr.rd_word | line_rd[w][arr.word_sel];
            end
        end
    end

endmodule

// ==== source/icache_repl.sv ====
module icache_repl #(
    parameter int unsigned NUM_WAYS = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic [NUM_WAYS-1:0] way_valid_i,
    input  logic                advance_i,
    output logic [NUM_WAYS-1:0] victim_o
);

    // ------------------------------------------------------------
    // 8 bit lfsr for the full-set case
    // ------------------------------------------------------------

    logic [7:0]          lfsr_q;
    logic                lfsr_fb;
    logic [NUM_WAYS-1:0] first_inv;
    logic                inv_found;
    logic [NUM_WAYS-1:0] rand_way;

    // taps 8,6,5,4 give the maximal length sequence
    assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    // only steps when the controller actually evicts a valid line
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lfsr_q <= 8'hA5;
        end else if (advance_i) begin
            lfsr_q <= {lfsr_q[6:0], lfsr_fb};
        end
    end

    // lowest numbered invalid way wins
    always_comb begin
        first_inv = '0;
        inv_found = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!way_valid_i[w] && !inv_found) begin
                first_inv[w] = 1'b1;
                inv_found    = 1'b1;
            end
        end
        // lfsr value folded onto the way count
        rand_way                   = '0;
        rand_way[lfsr_q % NUM_WAYS] = 1'b1;
    end

    assign victim_o = inv_found ? first_inv : rand_way;

endmodule

// ==== source/icache_ctrl.sv ====
module icache_ctrl #(
    parameter int unsigned NUM_WAYS = 4,
    parameter int unsigned NUM_SETS = 16
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    en_i,
    // fetch port
    input  logic                    fetch_req_i,
    input  icache_pkg::fetch_addr_t fetch_addr_i,
    output logic                    fetch_ready_o,
    output logic                    fetch_valid_o,
    output icache_pkg::fetch_word_t fetch_data_o,
    output logic                    miss_o,
    // memory read port
    output logic                    mem_ar_valid_o,
    input  logic                    mem_ar_ready_i,
    output icache_pkg::fetch_addr_t mem_ar_addr_o,
    input  logic                    mem_r_valid_i,
    input  icache_pkg::beat_t       mem_r_data_i,
    input  logic                    mem_r_last_i,
    // arrays and replacement
    icache_array_if.ctrl            arr,
    input  logic [NUM_WAYS-1:0]     victim_i,
    output logic                    repl_advance_o
);
    import icache_pkg::*;

    localparam int unsigned INDEX_W    = $clog2(NUM_SETS);
    localparam int unsigned TAG_W      = ADDR_WIDTH - INDEX_W - LINE_OFFSET_WIDTH;
    localparam int unsigned WORD_LSB   = $clog2(FETCH_WIDTH / 8);
    localparam int unsigned WORD_SEL_W = LINE_OFFSET_WIDTH - WORD_LSB;
    localparam int unsigned BEAT_SEL_W = $clog2(BEATS_PER_LINE);

    ctrl_state_e           state_q, state_d;
    fetch_addr_t           addr_q, addr_d;
    logic [TAG_W-1:0]      tag_q, tag_d;
    logic [NUM_WAYS-1:0]   evict_way_q, evict_way_d;
    logic [INDEX_W-1:0]    flush_cnt_q, flush_cnt_d;
    logic                  flush_pend_q, flush_pend_d;
    logic [BEAT_SEL_W-1:0] beat_cnt_q, beat_cnt_d;

    logic [INDEX_W-1:0] addr_index;
    logic [TAG_W-1:0]   addr_tag;
    logic               flush_block;
    logic               lookup_hit;

    // fields of the held address
    assign addr_index = addr_q[LINE_OFFSET_WIDTH +: INDEX_W];
    assign addr_tag   = addr_q[ADDR_WIDTH-1 -: TAG_W];

    // no new fetch is taken once a flush is requested
    assign flush_block = flush_i || flush_pend_q;
    // in bypass only the replay after a refill may hit
    assign lookup_hit  = (|arr.hit) && (en_i || (state_q == TAG_CMP_SAVED));

    // line aligned and built only from registers so it holds through REFILL
    assign mem_ar_addr_o = {tag_q, addr_index, {LINE_OFFSET_WIDTH{1'b0}}};
    assign fetch_data_o  = arr.rd_word;

    // ------------------------------------------------------------
    // lookup, refill and flush FSM
    // ------------------------------------------------------------
    always_comb begin
        state_d      = state_q;
        addr_d       = addr_q;
        tag_d        = tag_q;
        evict_way_d  = evict_way_q;
        flush_cnt_d  = flush_cnt_q;
        flush_pend_d = flush_pend_q;
        beat_cnt_d   = beat_cnt_q;

        fetch_ready_o  = 1'b0;
        fetch_valid_o  = 1'b0;
        miss_o         = 1'b0;
        mem_ar_valid_o = 1'b0;
        repl_advance_o = 1'b0;

        // array defaults serve the refill write path
        arr.rd_en    = 1'b0;
        arr.index    = addr_index;
        arr.we       = 1'b0;
        arr.way_mask = evict_way_q;
        arr.beat_sel = beat_cnt_q;
        arr.wr_beat  = mem_r_data_i;
        arr.wr_tag   = tag_q;
        arr.wr_valid = 1'b1;
        arr.word_sel = addr_q[WORD_LSB +: WORD_SEL_W];
        // the held address keeps its tag through refill and replay
        arr.cmp_tag  = addr_tag;

        case (state_q)
            // clear the valid bit of every way one set per cycle
            FLUSH: begin
                arr.we       = 1'b1;
                arr.way_mask = '1;
                arr.wr_valid = 1'b0;
                arr.index    = flush_cnt_q;
                flush_cnt_d  = flush_cnt_q + 1'b1;
                if (flush_cnt_q == INDEX_W'(NUM_SETS - 1)) begin
                    flush_cnt_d  = '0;
                    flush_pend_d = 1'b0;
                    state_d      = IDLE;
                end
            end
            IDLE: begin
                fetch_ready_o = !flush_block;
                if (flush_block) begin
                    state_d = FLUSH;
                end else if (fetch_req_i) begin
                    // read all ways now, compare next cycle
                    addr_d    = fetch_addr_i;
                    arr.rd_en = 1'b1;
                    arr.index = fetch_addr_i[LINE_OFFSET_WIDTH +: INDEX_W];
                    state_d   = TAG_CMP;
                end
            end
            TAG_CMP, TAG_CMP_SAVED: begin
                if (lookup_hit) begin
                    fetch_valid_o = 1'b1;
                    fetch_ready_o = !flush_block;
                    state_d       = IDLE;
                    // a back to back request starts its read right away
                    if (fetch_req_i && !flush_block) begin
                        addr_d    = fetch_addr_i;
                        arr.rd_en = 1'b1;
                        arr.index = fetch_addr_i[LINE_OFFSET_WIDTH +: INDEX_W];
                        state_d   = TAG_CMP;
                    end
                end else begin
                    state_d = REFILL;
                    tag_d   = addr_tag;
                    miss_o  = en_i && (state_q == TAG_CMP);
                    // a bypass hit refreshes the way it already sits in
                    evict_way_d = arr.hit;
                    if (!(|arr.hit)) begin
                        evict_way_d    = victim_i;
                        repl_advance_o = &arr.way_valid;
                    end
                end
            end
            // hold the address phase until the memory takes it
            REFILL: begin
                mem_ar_valid_o = 1'b1;
                beat_cnt_d     = '0;
                if (mem_ar_ready_i) begin
                    state_d = WAIT_R;
                end
            end
            // each beat goes straight into the victim way
            WAIT_R: begin
                if (mem_r_valid_i) begin
                    arr.we     = 1'b1;
                    beat_cnt_d = beat_cnt_q + 1'b1;
                    if (mem_r_last_i) begin
                        state_d = REDO_REQ;
                    end
                end
            end
            // reread the refilled set for the replay compare
            REDO_REQ: begin
                arr.rd_en = 1'b1;
                state_d   = TAG_CMP_SAVED;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // remember a flush until FLUSH has run
        if (flush_i) begin
            flush_pend_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= FLUSH;
            evict_way_q  <= '0;
            flush_cnt_q  <= '0;
            flush_pend_q <= 1'b0;
            beat_cnt_q   <= '0;
        end else begin
            state_q      <= state_d;
            evict_way_q  <= evict_way_d;
            flush_cnt_q  <= flush_cnt_d;
            flush_pend_q <= flush_pend_d;
            beat_cnt_q   <= beat_cnt_d;
        end
    end

    // held fetch address and the tag of the line being refilled
    always_ff @(posedge clk_i) begin
        addr_q <= addr_d;
        tag_q  <= tag_d;
    end

endmodule

// ==== source/icache_top.sv ====
module icache_top #(
    parameter int unsigned NUM_WAYS = 4,
    parameter int unsigned NUM_SETS = 16
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    en_i,
    // fetch port
    input  logic                    fetch_req_i,
    input  icache_pkg::fetch_addr_t fetch_addr_i,
    output logic                    fetch_ready_o,
    output logic                    fetch_valid_o,
    output icache_pkg::fetch_word_t fetch_data_o,
    output logic                    miss_o,
    // memory read port
    output logic                    mem_ar_valid_o,
    input  logic                    mem_ar_ready_i,
    output icache_pkg::fetch_addr_t mem_ar_addr_o,
    input  logic                    mem_r_valid_i,
    input  icache_pkg::beat_t       mem_r_data_i,
    input  logic                    mem_r_last_i
);

    // victim choice back to the controller
    logic [NUM_WAYS-1:0] repl_victim;
    logic                repl_advance;

    // ------------------------------------------------------------
    // controller to arrays link
    // ------------------------------------------------------------
    icache_array_if #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) u_array_if ();

    icache_ctrl #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .en_i           (en_i),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ready_o  (fetch_ready_o),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_data_o   (fetch_data_o),
        .miss_o         (miss_o),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_ar_addr_o  (mem_ar_addr_o),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_data_i   (mem_r_data_i),
        .mem_r_last_i   (mem_r_last_i),
        .arr            (u_array_if.ctrl),
        .victim_i       (repl_victim),
        .repl_advance_o (repl_advance)
    );

    icache_arrays #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) u_arrays (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .arr    (u_array_if.arrays)
    );

    // valid bits come from the same read as the compare
    icache_repl #(
        .NUM_WAYS (NUM_WAYS)
    ) u_repl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .way_valid_i (u_array_if.way_valid),
        .advance_i   (repl_advance),
        .victim_o    (repl_victim)
    );

endmodule

// ==== dv/icache_scoreboard.sv ====
module icache_scoreboard #(
    parameter int unsigned TIMEOUT_CYCLES = 200
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    en_i,
    input  logic                    fetch_req_i,
    input  logic                    fetch_ready_i,
    input  logic                    fetch_valid_i,
    input  icache_pkg::fetch_word_t fetch_data_i,
    input  logic                    miss_i,
    input  logic                    ar_valid_i,
    input  logic                    ar_ready_i,
    input  icache_pkg::fetch_addr_t ar_addr_i,
    output int                      accepts_o,
    output int                      tests_o,
    output int                      errors_o
);
    import icache_pkg::*;

    // expected results in request order
    string       exp_name_q [$];
    fetch_addr_t exp_addr_q [$];
    fetch_word_t exp_word_q [$];
    logic        exp_miss_q [$];

    // the one fetch the cache holds in flight
    logic        active   = 1'b0;
    string       cur_name;
    fetch_addr_t cur_addr;
    fetch_word_t cur_word;
    logic        cur_miss;
    logic        cur_en;
    int          miss_cnt;
    int          ar_cnt;
    int          wait_cyc;
    logic        cur_bad;

    int accepts_q      = 0;
    int tests_q        = 0;
    int errors_q       = 0;
    int reset_errors_q = 0;

    assign accepts_o = accepts_q;
    assign tests_o   = tests_q;
    assign errors_o  = errors_q + reset_errors_q;

    task automatic add_expect(input string name, input fetch_addr_t addr,
                              input fetch_word_t word, input logic miss);
        exp_name_q.push_back(name);
        exp_addr_q.push_back(addr);
        exp_word_q.push_back(word);
        exp_miss_q.push_back(miss);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("FAILED %s %s expected %h actual %h", cur_name, what, exp_v, act_v);
        errors_q++;
        cur_bad = 1'b1;
    endtask

    // ------------------------------------------------------------
    // end of one fetch
    // ------------------------------------------------------------
    task automatic close_test();
        int exp_ar;
        // bypass refetches every line even without a counted miss
        exp_ar = (cur_miss || !cur_en) ? 1 : 0;
        if (fetch_data_i !== cur_word) begin
            report_mismatch("word", cur_word, fetch_data_i);
        end
        if (miss_cnt != int'(cur_miss)) begin
            report_mismatch("misses", 32'(cur_miss), 32'(miss_cnt));
        end
        if (ar_cnt != exp_ar) begin
            report_mismatch("memory requests", 32'(exp_ar), 32'(ar_cnt));
        end
        if (!cur_bad) begin
            $display("passed %s word %h", cur_name, fetch_data_i);
        end
        tests_q++;
        active = 1'b0;
    endtask

    // the fetch and memory ports stay quiet while reset is held
    always @(negedge clk_i) begin
        if (!rst_ni && ({fetch_ready_i, fetch_valid_i, miss_i, ar_valid_i} !== 4'b0000)) begin
            $display("FAILED reset outputs expected %h actual %h", 4'h0,
                     {fetch_ready_i, fetch_valid_i, miss_i, ar_valid_i});
            reset_errors_q++;
        end
    end

    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (active) begin
                if (miss_i) begin
                    miss_cnt++;
                end
                if (ar_valid_i && ar_ready_i) begin
                    ar_cnt++;
                    // burst must start at the line holding the fetch
                    if (ar_addr_i !== (cur_addr & ~32'hF)) begin
                        report_mismatch("line address", cur_addr & ~32'hF, ar_addr_i);
                    end
                end
                if (fetch_valid_i) begin
                    close_test();
                end else begin
                    wait_cyc++;
                    if (wait_cyc >= int'(TIMEOUT_CYCLES)) begin
                        $display("fetch %s got no valid response within %0d cycles",
                                 cur_name, TIMEOUT_CYCLES);
                        errors_q++;
                        tests_q++;
                        active = 1'b0;
                    end
                end
            end else if (fetch_valid_i) begin
                $display("fetch valid seen with no request outstanding");
                errors_q++;
            end
            // a new request may be taken in the same cycle as a hit
            if (fetch_req_i && fetch_ready_i) begin
                accepts_q++;
                if (exp_name_q.size() == 0) begin
                    $display("fetch accepted with no expected result queued");
                    errors_q++;
                end else begin
                    cur_name = exp_name_q.pop_front();
                    cur_addr = exp_addr_q.pop_front();
                    cur_word = exp_word_q.pop_front();
                    cur_miss = exp_miss_q.pop_front();
                    cur_en   = en_i;
                    miss_cnt = 0;
                    ar_cnt   = 0;
                    wait_cyc = 0;
                    cur_bad  = 1'b0;
                    active   = 1'b1;
                end
            end
        end
    end

endmodule

// ==== dv/icache_assert_chk.sv ====
module icache_assert_chk #(
    parameter int unsigned NUM_WAYS = 4
) (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic [NUM_WAYS-1:0]     hit_i,
    input icache_pkg::ctrl_state_e state_i,
    input logic                    fetch_valid_o,
    input logic                    mem_ar_valid_o,
    input logic                    mem_ar_ready_i,
    input icache_pkg::fetch_addr_t mem_ar_addr_o
);
    import icache_pkg::*;

    // a line lives in one way only
    hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit_i))
        else $error("more than one way hit");

    // address phase holds until taken
    ar_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_ar_valid_o && !mem_ar_ready_i |=> $stable(mem_ar_addr_o))
        else $error("memory address changed while waiting for ready");

    flush_no_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_i == FLUSH |-> !fetch_valid_o)
        else $error("fetch valid during flush");

endmodule

bind icache_top icache_assert_chk #(
    .NUM_WAYS (NUM_WAYS)
) u_assert_chk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .hit_i          (u_array_if.hit),
    .state_i        (u_ctrl.state_q),
    .fetch_valid_o  (fetch_valid_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o)
);

// ==== dv/icache_tb.sv ====
module icache_tb;
    import icache_pkg::*;

    localparam int unsigned NUM_WAYS      = 4;
    localparam int unsigned NUM_SETS      = 16;
    localparam int unsigned CMD_CYCLES    = 200;
    localparam logic [31:0] SEED          = 32'h10784209;

    logic        clk_i;
    logic        rst_ni;
    logic        flush_i;
    logic        en_i;
    logic        fetch_req_i;
    fetch_addr_t fetch_addr_i;
    logic        fetch_ready_o;
    logic        fetch_valid_o;
    fetch_word_t fetch_data_o;
    logic        miss_o;
    logic        mem_ar_valid_o;
    logic        mem_ar_ready_i;
    fetch_addr_t mem_ar_addr_o;
    logic        mem_r_valid_i;
    beat_t       mem_r_data_i;
    logic        mem_r_last_i;

    int accepts;
    int tests;
    int sb_errors;
    int tb_errors = 0;
    int issued    = 0;
    int limit_cycles = 0;

    // commands read from the stimulus file
    string       cmd_kind_q [$];
    string       cmd_name_q [$];
    fetch_addr_t cmd_addr_q [$];
    fetch_word_t cmd_word_q [$];
    int          cmd_val_q  [$];

    icache_top #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) u_icache_top (.*);

    icache_scoreboard #(
        .TIMEOUT_CYCLES (CMD_CYCLES)
    ) u_scoreboard (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .en_i          (en_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_ready_i (fetch_ready_o),
        .fetch_valid_i (fetch_valid_o),
        .fetch_data_i  (fetch_data_o),
        .miss_i        (miss_o),
        .ar_valid_i    (mem_ar_valid_o),
        .ar_ready_i    (mem_ar_ready_i),
        .ar_addr_i     (mem_ar_addr_o),
        .accepts_o     (accepts),
        .tests_o       (tests),
        .errors_o      (sb_errors)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // memory word at a byte address
    function automatic fetch_word_t mem_word(input fetch_addr_t a);
        return a ^ 32'hC0DE0000;
    endfunction

    // ------------------------------------------------------------
    // memory model, random ready delay and beat gaps
    // ------------------------------------------------------------
    task automatic serve_memory();
        fetch_addr_t line;
        forever begin
            @(negedge clk_i);
            if (mem_ar_valid_o) begin
                line = mem_ar_addr_o;
                repeat ($urandom_range(3, 0)) @(negedge clk_i);
                mem_ar_ready_i = 1'b1;
                @(negedge clk_i);
                mem_ar_ready_i = 1'b0;
                for (int b = 0; b < 2; b++) begin
                    repeat ($urandom_range(2, 0)) @(negedge clk_i);
                    // lower word in the lower half of the beat
                    mem_r_data_i  = {mem_word(line + 32'(8 * b + 4)),
                                     mem_word(line + 32'(8 * b))};
                    mem_r_valid_i = 1'b1;
                    mem_r_last_i  = (b == 1);
                    @(negedge clk_i);
                    mem_r_valid_i = 1'b0;
                    mem_r_last_i  = 1'b0;
                end
            end
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    n;
        string kind;
        string name;
        string rest;
        fetch_addr_t a;
        fetch_word_t w;
        int    v;
        fd = $fopen("dv/icache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                break;
            end
            name = "";
            a    = '0;
            w    = '0;
            v    = 0;
            if (kind == "#") begin
                n = $fgets(rest, fd);
                continue;
            end else if (kind == "enable") begin
                n = $fscanf(fd, "%d", v);
            end else if (kind == "fetch") begin
                n = $fscanf(fd, "%s %h %h %d", name, a, w, v);
            end else if (kind != "flush") begin
                $display("unknown command %s in the stimulus file", kind);
                tb_errors++;
                continue;
            end
            cmd_kind_q.push_back(kind);
            cmd_name_q.push_back(name);
            cmd_addr_q.push_back(a);
            cmd_word_q.push_back(w);
            cmd_val_q.push_back(v);
        end
        $fclose(fd);
    endtask

    // request stays up until taken, the next one may follow at once
    task automatic issue_fetch(input int i);
        int target;
        u_scoreboard.add_expect(cmd_name_q[i], cmd_addr_q[i], cmd_word_q[i],
                                cmd_val_q[i] != 0);
        issued++;
        target       = accepts + 1;
        fetch_req_i  = 1'b1;
        fetch_addr_i = cmd_addr_q[i];
        do begin
            @(negedge clk_i);
        end while (accepts != target);
    endtask

    task automatic drain();
        fetch_req_i = 1'b0;
        while (tests != issued) begin
            @(negedge clk_i);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        en_i           = 1'b1;
        fetch_req_i    = 1'b0;
        fetch_addr_i   = '0;
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i  = 1'b0;
        mem_r_data_i   = '0;
        mem_r_last_i   = 1'b0;
        read_stimulus();
        limit_cycles = (cmd_kind_q.size() + 2) * CMD_CYCLES;
        fork
            serve_memory();
        join_none
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < cmd_kind_q.size(); i++) begin
            if (cmd_kind_q[i] == "fetch") begin
                issue_fetch(i);
            end else begin
                drain();
                if (cmd_kind_q[i] == "flush") begin
                    flush_i = 1'b1;
                end else begin
                    en_i = (cmd_val_q[i] != 0);
                end
                @(negedge clk_i);
                flush_i = 1'b0;
            end
        end
        drain();
        repeat (4) @(negedge clk_i);
        $display("summary %0d tests, %0d errors", tests, sb_errors + tb_errors);
        if (sb_errors + tb_errors == 0 && tests > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, run did not finish", limit_cycles);
        $display("summary %0d tests, %0d errors", tests, sb_errors + tb_errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== dv/icache_stimulus.txt ====
# columns: fetch <name> <address hex> <expected word hex> <expected miss 0/1>
# also: flush, enable <0/1>
enable 1
fetch cold_miss 00002040 c0de2040 1
fetch same_line_w1 00002044 c0de2044 0
fetch same_line_w2 00002048 c0de2048 0
fetch same_line_w3 0000204c c0de204c 0
flush
fetch set0_a1 00001000 c0de1000 1
fetch set0_b1 00001100 c0de1100 1
fetch set0_c1 00001200 c0de1200 1
fetch set0_d1 00001300 c0de1300 1
fetch set0_e1 00001400 c0de1400 1
fetch set0_a2 00001008 c0de1008 0
fetch set0_b2 00001108 c0de1108 1
fetch set0_c2 00001208 c0de1208 1
fetch set0_d2 00001308 c0de1308 0
fetch set0_e2 00001408 c0de1408 1
fetch before_flush 00001304 c0de1304 0
flush
fetch after_flush 00001304 c0de1304 1
enable 0
fetch bypass_1 00003010 c0de3010 0
fetch bypass_2 00003010 c0de3010 0
fetch bypass_3 00003010 c0de3010 0
enable 1
fetch b2b_a 00004000 c0de4000 1
fetch b2b_b 00004004 c0de4004 0
fetch b2b_c 00004010 c0de4010 1
fetch b2b_d 00004014 c0de4014 0
fetch b2b_e 00004000 c0de4000 0
fetch b2b_f 00005000 c0de5000 1

// ==== icache.f ====
source/icache_pkg.sv
source/icache_array_if.sv
source/icache_arrays.sv
source/icache_repl.sv
source/icache_ctrl.sv
source/icache_top.sv
dv/icache_scoreboard.sv
dv/icache_assert_chk.sv
dv/icache_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module icache_tb -Mdir obj_dir -f icache.f
	./obj_dir/Vicache_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
